// ==== src/decode_pkg.sv ====
`default_nettype none

package decode_pkg;

        typedef logic [31:0] inst_t;
        typedef logic [5:0]  opcode_t;
        typedef logic [5:0]  funct_t;
        typedef logic [4:0]  reg_addr_t;

        typedef enum logic [5:0] {
                ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
                ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_LUI,
                ALU_SLL, ALU_SRL, ALU_SRA,
                ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU,
                ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
                ALU_BREK, ALU_SYSC, ALU_ERET, ALU_MFC0, ALU_MTC0,
                ALU_OUTA // Passes PC+8 for link
        } alu_op_t;

        typedef enum logic [1:0] {
                SRC_REG, // Operand 2 from rt
                SRC_IMM,
                SRC_SFT, // Shift amount field
                SRC_PCA
        } alu_src_t;

        typedef enum logic {
                EXT_SIGN = 1'b0,
                EXT_ZERO = 1'b1
        } ext_t;

        typedef enum logic [1:0] {
                MEM_NOOP, MEM_LOAD, MEM_STOR
        } mem_type_t;

        typedef enum logic [1:0] {
                SZ_BYTE, SZ_HALF, SZ_FULL
        } mem_size_t;

        localparam reg_addr_t LINK_REG = 5'd31; // Link target for JAL family

        // Primary opcodes
        localparam opcode_t OP_SPECIAL = 6'b000000;
        localparam opcode_t OP_REGIMM  = 6'b000001;
        localparam opcode_t OP_J       = 6'b000010;
        localparam opcode_t OP_JAL     = 6'b000011;
        localparam opcode_t OP_BEQ     = 6'b000100;
        localparam opcode_t OP_BNE     = 6'b000101;
        localparam opcode_t OP_BLEZ    = 6'b000110;
        localparam opcode_t OP_BGTZ    = 6'b000111;
        localparam opcode_t OP_ADDI    = 6'b001000;
        localparam opcode_t OP_ADDIU   = 6'b001001;
        localparam opcode_t OP_SLTI    = 6'b001010;
        localparam opcode_t OP_SLTIU   = 6'b001011;
        localparam opcode_t OP_ANDI    = 6'b001100;
        localparam opcode_t OP_ORI     = 6'b001101;
        localparam opcode_t OP_XORI    = 6'b001110;
        localparam opcode_t OP_LUI     = 6'b001111;
        localparam opcode_t OP_COP0    = 6'b010000;
        localparam opcode_t OP_LB      = 6'b100000;
        localparam opcode_t OP_LH      = 6'b100001;
        localparam opcode_t OP_LW      = 6'b100011;
        localparam opcode_t OP_LBU     = 6'b100100;
        localparam opcode_t OP_LHU     = 6'b100101;
        localparam opcode_t OP_SB      = 6'b101000;
        localparam opcode_t OP_SH      = 6'b101001;
        localparam opcode_t OP_SW      = 6'b101011;

        // SPECIAL function codes
        localparam funct_t FN_SLL     = 6'b000000;
        localparam funct_t FN_SRL     = 6'b000010;
        localparam funct_t FN_SRA     = 6'b000011;
        localparam funct_t FN_SLLV    = 6'b000100;
        localparam funct_t FN_SRLV    = 6'b000110;
        localparam funct_t FN_SRAV    = 6'b000111;
        localparam funct_t FN_JR      = 6'b001000;
        localparam funct_t FN_JALR    = 6'b001001;
        localparam funct_t FN_SYSCALL = 6'b001100;
        localparam funct_t FN_BREAK   = 6'b001101;
        localparam funct_t FN_MFHI    = 6'b010000;
        localparam funct_t FN_MTHI    = 6'b010001;
        localparam funct_t FN_MFLO    = 6'b010010;
        localparam funct_t FN_MTLO    = 6'b010011;
        localparam funct_t FN_MULT    = 6'b011000;
        localparam funct_t FN_MULTU   = 6'b011001;
        localparam funct_t FN_DIV     = 6'b011010;
        localparam funct_t FN_DIVU    = 6'b011011;
        localparam funct_t FN_ADD     = 6'b100000;
        localparam funct_t FN_ADDU    = 6'b100001;
        localparam funct_t FN_SUB     = 6'b100010;
        localparam funct_t FN_SUBU    = 6'b100011;
        localparam funct_t FN_AND     = 6'b100100;
        localparam funct_t FN_OR      = 6'b100101;
        localparam funct_t FN_XOR     = 6'b100110;
        localparam funct_t FN_NOR     = 6'b100111;
        localparam funct_t FN_SLT     = 6'b101010;
        localparam funct_t FN_SLTU    = 6'b101011;

        // REGIMM branch selectors in the rt field
        localparam reg_addr_t RT_BLTZ   = 5'b00000;
        localparam reg_addr_t RT_BGEZ   = 5'b00001;
        localparam reg_addr_t RT_BLTZAL = 5'b10000;
        localparam reg_addr_t RT_BGEZAL = 5'b10001;

        localparam inst_t     ERET_WORD = 32'h4200_0018;
        localparam reg_addr_t COP0_MF   = 5'b00000; // rs of MFC0
        localparam reg_addr_t COP0_MT   = 5'b00100; // rs of MTC0

        typedef struct packed {
                inst_t     inst;
                opcode_t   opcode;
                reg_addr_t rs;
                reg_addr_t rt;
                reg_addr_t rd;
                funct_t    funct;
                logic      is_branch;
                logic      is_branch_al; // Branch that links to r31
        } inst_fields_t;

        typedef struct packed {
                alu_op_t   alu_op;
                alu_src_t  alu_src;
                ext_t      imm_ext;
                mem_type_t mem_type;
                mem_size_t mem_size;
                reg_addr_t wb_dest;
                logic      wb_en;
                ext_t      load_ext;
                logic      priv_inst;
                logic      undefined_inst;
        } ctrl_t;

        localparam ctrl_t CTRL_DEFAULT = '{
                alu_op:         ALU_ADDU,
                alu_src:        SRC_REG,
                imm_ext:        EXT_SIGN,
                mem_type:       MEM_NOOP,
                mem_size:       SZ_FULL,
                wb_dest:        '0,
                wb_en:          1'b0,
                load_ext:       EXT_ZERO,
                priv_inst:      1'b0,
                undefined_inst: 1'b0
        };

endpackage

`default_nettype wire

// ==== src/branch_classify.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_classify (
        input  logic                     clk,
        input  logic                     rst,
        input  logic                     inst_valid,
        input  decode_pkg::inst_t        inst,
        output logic                     fields_valid,
        output decode_pkg::inst_fields_t fields
);
        import decode_pkg::*;

        inst_fields_t fields_d;

        always_comb begin
                fields_d.inst         = inst;
                fields_d.opcode       = inst[31:26];
                fields_d.rs           = inst[25:21];
                fields_d.rt           = inst[20:16];
                fields_d.rd           = inst[15:11];
                fields_d.funct        = inst[5:0];
                fields_d.is_branch    = 1'b0;
                fields_d.is_branch_al = 1'b0;

                case (fields_d.opcode)
                        OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J:
                                fields_d.is_branch = 1'b1;
                        OP_JAL: begin
                                fields_d.is_branch    = 1'b1;
                                fields_d.is_branch_al = 1'b1;
                        end
                        OP_REGIMM: begin
                                case (fields_d.rt) // Branch kind sits in rt
                                        RT_BLTZ, RT_BGEZ:
                                                fields_d.is_branch = 1'b1;
                                        RT_BLTZAL, RT_BGEZAL: begin
                                                fields_d.is_branch    = 1'b1;
                                                fields_d.is_branch_al = 1'b1;
                                        end
                                        default: ;
                                endcase
                        end
                        OP_SPECIAL:
                                // JALR treated as a plain jump here
                                fields_d.is_branch = (fields_d.funct == FN_JR) ||
                                                     (fields_d.funct == FN_JALR);
                        default: ;
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        fields_valid <= 1'b0;
                        fields       <= '0;
                end else begin
                        fields_valid <= inst_valid;
                        fields       <= fields_d;
                end
        end

endmodule

`default_nettype wire

// ==== src/ctrl_table.sv ====
`timescale 1ns/10ps
`default_nettype none

module ctrl_table (
        input  logic                     clk,
        input  logic                     rst,
        input  logic                     fields_valid,
        input  decode_pkg::inst_fields_t fields,
        output logic                     ctrl_valid,
        output decode_pkg::ctrl_t        ctrl
);
        import decode_pkg::*;

        ctrl_t     ctrl_d;
        reg_addr_t rd;
        reg_addr_t rt;

        // Plain ALU op with a chosen operand source
        function automatic ctrl_t r_ctrl(alu_op_t op, alu_src_t src, reg_addr_t dest,
                                         logic wb);
                ctrl_t c;
                c         = CTRL_DEFAULT;
                c.alu_op  = op;
                c.alu_src = src;
                c.wb_dest = dest;
                c.wb_en   = wb;
                return c;
        endfunction

        function automatic ctrl_t i_ctrl(alu_op_t op, ext_t ext, reg_addr_t dest);
                ctrl_t c;
                c         = r_ctrl(op, SRC_IMM, dest, 1'b1);
                c.imm_ext = ext;
                return c;
        endfunction

        // Address is base plus sign-extended offset
        function automatic ctrl_t m_ctrl(mem_type_t mt, mem_size_t ms, ext_t lext,
                                         reg_addr_t dest);
                ctrl_t c;
                c          = r_ctrl(ALU_ADDU, SRC_IMM, dest, mt == MEM_LOAD);
                c.mem_type = mt;
                c.mem_size = ms;
                c.load_ext = lext;
                return c;
        endfunction

        assign rd = fields.rd;
        assign rt = fields.rt;

        always_comb begin
                ctrl_d = CTRL_DEFAULT;
                casez ({fields.opcode, fields.funct})
                        {OP_SPECIAL, FN_ADD}:   ctrl_d = r_ctrl(ALU_ADD, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_ADDU}:  ctrl_d = r_ctrl(ALU_ADDU, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_SUB}:   ctrl_d = r_ctrl(ALU_SUB, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_SUBU}:  ctrl_d = r_ctrl(ALU_SUBU, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_SLT}:   ctrl_d = r_ctrl(ALU_SLT, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_SLTU}:  ctrl_d = r_ctrl(ALU_SLTU, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_AND}:   ctrl_d = r_ctrl(ALU_AND, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_OR}:    ctrl_d = r_ctrl(ALU_OR, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_XOR}:   ctrl_d = r_ctrl(ALU_XOR, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_NOR}:   ctrl_d = r_ctrl(ALU_NOR, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_SLL}:   ctrl_d = r_ctrl(ALU_SLL, SRC_SFT, rd, 1'b1);
                        {OP_SPECIAL, FN_SLLV}:  ctrl_d = r_ctrl(ALU_SLL, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_SRL}:   ctrl_d = r_ctrl(ALU_SRL, SRC_SFT, rd, 1'b1);
                        {OP_SPECIAL, FN_SRLV}:  ctrl_d = r_ctrl(ALU_SRL, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_SRA}:   ctrl_d = r_ctrl(ALU_SRA, SRC_SFT, rd, 1'b1);
                        {OP_SPECIAL, FN_SRAV}:  ctrl_d = r_ctrl(ALU_SRA, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_MULT}:  ctrl_d = r_ctrl(ALU_MULT, SRC_REG, rd, 1'b0);
                        {OP_SPECIAL, FN_MULTU}: ctrl_d = r_ctrl(ALU_MULTU, SRC_REG, rd, 1'b0);
                        {OP_SPECIAL, FN_DIV}:   ctrl_d = r_ctrl(ALU_DIV, SRC_REG, rd, 1'b0);
                        {OP_SPECIAL, FN_DIVU}:  ctrl_d = r_ctrl(ALU_DIVU, SRC_REG, rd, 1'b0);
                        {OP_SPECIAL, FN_MFHI}:  ctrl_d = r_ctrl(ALU_MFHI, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_MFLO}:  ctrl_d = r_ctrl(ALU_MFLO, SRC_REG, rd, 1'b1);
                        {OP_SPECIAL, FN_MTHI}:  ctrl_d = r_ctrl(ALU_MTHI, SRC_REG, rd, 1'b0);
                        {OP_SPECIAL, FN_MTLO}:  ctrl_d = r_ctrl(ALU_MTLO, SRC_REG, rd, 1'b0);
                        {OP_SPECIAL, FN_BREAK}: begin
                                ctrl_d           = r_ctrl(ALU_BREK, SRC_REG, rd, 1'b0);
                                ctrl_d.priv_inst = 1'b1;
                        end
                        {OP_SPECIAL, FN_SYSCALL}: begin
                                ctrl_d           = r_ctrl(ALU_SYSC, SRC_REG, rd, 1'b0);
                                ctrl_d.priv_inst = 1'b1;
                        end
                        {OP_ADDI, 6'b??????}:   ctrl_d = i_ctrl(ALU_ADD, EXT_SIGN, rt);
                        {OP_ADDIU, 6'b??????}:  ctrl_d = i_ctrl(ALU_ADDU, EXT_SIGN, rt);
                        {OP_SLTI, 6'b??????}:   ctrl_d = i_ctrl(ALU_SLT, EXT_SIGN, rt);
                        {OP_SLTIU, 6'b??????}:  ctrl_d = i_ctrl(ALU_SLTU, EXT_SIGN, rt);
                        {OP_ANDI, 6'b??????}:   ctrl_d = i_ctrl(ALU_AND, EXT_ZERO, rt);
                        {OP_ORI, 6'b??????}:    ctrl_d = i_ctrl(ALU_OR, EXT_ZERO, rt);
                        {OP_XORI, 6'b??????}:   ctrl_d = i_ctrl(ALU_XOR, EXT_ZERO, rt);
                        {OP_LUI, 6'b??????}:    ctrl_d = i_ctrl(ALU_LUI, EXT_ZERO, rt);
                        {OP_LB, 6'b??????}:  ctrl_d = m_ctrl(MEM_LOAD, SZ_BYTE, EXT_SIGN, rt);
                        {OP_LBU, 6'b??????}: ctrl_d = m_ctrl(MEM_LOAD, SZ_BYTE, EXT_ZERO, rt);
                        {OP_LH, 6'b??????}:  ctrl_d = m_ctrl(MEM_LOAD, SZ_HALF, EXT_SIGN, rt);
                        {OP_LHU, 6'b??????}: ctrl_d = m_ctrl(MEM_LOAD, SZ_HALF, EXT_ZERO, rt);
                        {OP_LW, 6'b??????}:  ctrl_d = m_ctrl(MEM_LOAD, SZ_FULL, EXT_ZERO, rt);
                        {OP_SB, 6'b??????}:  ctrl_d = m_ctrl(MEM_STOR, SZ_BYTE, EXT_ZERO, rt);
                        {OP_SH, 6'b??????}:  ctrl_d = m_ctrl(MEM_STOR, SZ_HALF, EXT_ZERO, rt);
                        {OP_SW, 6'b??????}:  ctrl_d = m_ctrl(MEM_STOR, SZ_FULL, EXT_ZERO, rt);
                        {OP_COP0, 6'b??????}: begin
                                // ERET first, its rs would not match MFC0 or MTC0 anyway
                                if (fields.inst == ERET_WORD)
                                        ctrl_d = r_ctrl(ALU_ERET, SRC_REG, rt, 1'b0);
                                else if (fields.rs == COP0_MF)
                                        ctrl_d = r_ctrl(ALU_MFC0, SRC_REG, rt, 1'b1);
                                else if (fields.rs == COP0_MT)
                                        ctrl_d = r_ctrl(ALU_MTC0, SRC_REG, rt, 1'b0);
                                else
                                        ctrl_d.undefined_inst = 1'b1;
                                ctrl_d.priv_inst = 1'b1; // Whole COP0 group
                        end
                        default: begin
                                if (fields.is_branch && fields.is_branch_al)
                                        ctrl_d = r_ctrl(ALU_OUTA, SRC_PCA, LINK_REG, 1'b1);
                                else
                                        ctrl_d.undefined_inst = ~fields.is_branch;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        ctrl_valid <= 1'b0;
                        ctrl       <= '0;
                end else begin
                        ctrl_valid <= fields_valid;
                        ctrl       <= ctrl_d;
                end
        end

endmodule

`default_nettype wire

// ==== src/decode_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_top (
        input  logic              clk,
        input  logic              rst,
        input  logic              inst_valid,
        input  decode_pkg::inst_t inst,
        output logic              ctrl_valid,
        output decode_pkg::ctrl_t ctrl
);
        import decode_pkg::*;

        logic         fields_valid;
        inst_fields_t fields; // Classified word, one cycle behind inst

        branch_classify i_classify (
                .clk          (clk),
                .rst          (rst),
                .inst_valid   (inst_valid),
                .inst         (inst),
                .fields_valid (fields_valid),
                .fields       (fields)
        );

        ctrl_table i_ctrl (
                .clk          (clk),
                .rst          (rst),
                .fields_valid (fields_valid),
                .fields       (fields),
                .ctrl_valid   (ctrl_valid),
                .ctrl         (ctrl)
        );

endmodule

`default_nettype wire

// ==== test/decode_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module decode_assertions (
        input logic              clk,
        input logic              rst,
        input logic              inst_valid,
        input logic              ctrl_valid,
        input decode_pkg::ctrl_t ctrl
);

        // Output stays quiet through reset and one cycle past it
        a_reset_quiet: assert property (@(posedge clk) rst |=> !ctrl_valid ##1 !ctrl_valid)
                else $error("ctrl_valid high during or right after reset");

        a_latency: assert property (@(posedge clk) disable iff (rst)
                ctrl_valid == $past(inst_valid, 2))
                else $error("ctrl_valid does not follow inst_valid by two cycles");

        a_wb_defined: assert property (@(posedge clk)
                (ctrl_valid && ctrl.wb_en) |-> !ctrl.undefined_inst)
                else $error("writeback enabled on an undefined instruction");

endmodule

bind decode_top decode_assertions i_assertions (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .ctrl_valid (ctrl_valid),
        .ctrl       (ctrl)
);

`default_nettype wire

// ==== test/decode_ref.svh ====
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH
`default_nettype none

// Expected control bundle for one instruction word
function automatic ctrl_t decode_ref(inst_t w);
        ctrl_t     c;
        opcode_t   op;
        funct_t    fn;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        logic      link;
        logic      jump;
        logic      known;
        op = w[31:26];
        rs = w[25:21];
        rt = w[20:16];
        rd = w[15:11];
        fn = w[5:0];
        link = (op == OP_JAL) || (op == OP_REGIMM && rt inside {RT_BLTZAL, RT_BGEZAL});
        jump = link || (op inside {OP_J, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ}) ||
               (op == OP_REGIMM && rt inside {RT_BLTZ, RT_BGEZ}) ||
               (op == OP_SPECIAL && fn inside {FN_JR, FN_JALR});
        c = '{ALU_ADDU, SRC_REG, EXT_SIGN, MEM_NOOP, SZ_FULL, 5'd0, 1'b0, EXT_ZERO, 1'b0, 1'b0};
        known = 1'b1;
        case (op)
                OP_SPECIAL: begin
                        case (fn)
                                FN_ADD: c.alu_op = ALU_ADD;
                                FN_ADDU: c.alu_op = ALU_ADDU;
                                FN_SUB: c.alu_op = ALU_SUB;
                                FN_SUBU: c.alu_op = ALU_SUBU;
                                FN_SLT: c.alu_op = ALU_SLT;
                                FN_SLTU: c.alu_op = ALU_SLTU;
                                FN_AND: c.alu_op = ALU_AND;
                                FN_OR: c.alu_op = ALU_OR;
                                FN_XOR: c.alu_op = ALU_XOR;
                                FN_NOR: c.alu_op = ALU_NOR;
                                FN_SLL, FN_SLLV: c.alu_op = ALU_SLL;
                                FN_SRL, FN_SRLV: c.alu_op = ALU_SRL;
                                FN_SRA, FN_SRAV: c.alu_op = ALU_SRA;
                                FN_MULT: c.alu_op = ALU_MULT;
                                FN_MULTU: c.alu_op = ALU_MULTU;
                                FN_DIV: c.alu_op = ALU_DIV;
                                FN_DIVU: c.alu_op = ALU_DIVU;
                                FN_MFHI: c.alu_op = ALU_MFHI;
                                FN_MFLO: c.alu_op = ALU_MFLO;
                                FN_MTHI: c.alu_op = ALU_MTHI;
                                FN_MTLO: c.alu_op = ALU_MTLO;
                                FN_BREAK: c.alu_op = ALU_BREK;
                                FN_SYSCALL: c.alu_op = ALU_SYSC;
                                default: known = 1'b0; // JR and JALR land here too
                        endcase
                        if (known) begin
                                c.wb_dest = rd;
                                c.wb_en = !(fn inside {FN_MULT, FN_MULTU, FN_DIV, FN_DIVU,
                                                       FN_MTHI, FN_MTLO, FN_BREAK, FN_SYSCALL});
                                c.priv_inst = fn inside {FN_BREAK, FN_SYSCALL};
                                if (fn inside {FN_SLL, FN_SRL, FN_SRA})
                                        c.alu_src = SRC_SFT;
                        end
                end
                OP_ADDI: c.alu_op = ALU_ADD;
                OP_SLTI: c.alu_op = ALU_SLT;
                OP_SLTIU: c.alu_op = ALU_SLTU;
                OP_ANDI: c.alu_op = ALU_AND;
                OP_ORI: c.alu_op = ALU_OR;
                OP_XORI: c.alu_op = ALU_XOR;
                OP_LUI: c.alu_op = ALU_LUI;
                OP_ADDIU, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW:
                        c.alu_op = ALU_ADDU;
                OP_COP0: begin
                        c.priv_inst = 1'b1;
                        c.wb_dest = rt;
                        if (w == ERET_WORD) begin
                                c.alu_op = ALU_ERET;
                        end else if (rs == COP0_MF) begin
                                c.alu_op = ALU_MFC0;
                                c.wb_en = 1'b1;
                        end else if (rs == COP0_MT) begin
                                c.alu_op = ALU_MTC0;
                        end else begin
                                c.wb_dest = 5'd0;
                                c.undefined_inst = 1'b1;
                        end
                end
                default: known = 1'b0;
        endcase
        if (known && op != OP_SPECIAL && op != OP_COP0) begin // Immediate format
                c.alu_src = SRC_IMM;
                c.wb_dest = rt;
                c.wb_en = !(op inside {OP_SB, OP_SH, OP_SW});
                if (op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI})
                        c.imm_ext = EXT_ZERO;
                if (op[5]) begin
                        if (op inside {OP_SB, OP_SH, OP_SW})
                                c.mem_type = MEM_STOR;
                        else
                                c.mem_type = MEM_LOAD;
                        if (op inside {OP_LB, OP_LBU, OP_SB})
                                c.mem_size = SZ_BYTE;
                        else if (op inside {OP_LH, OP_LHU, OP_SH})
                                c.mem_size = SZ_HALF;
                        if (op inside {OP_LB, OP_LH})
                                c.load_ext = EXT_SIGN;
                end
        end
        if (!known) begin
                if (link) begin
                        c.alu_op = ALU_OUTA;
                        c.alu_src = SRC_PCA;
                        c.wb_dest = LINK_REG;
                        c.wb_en = 1'b1;
                end else begin
                        c.undefined_inst = !jump;
                end
        end
        return c;
endfunction

`default_nettype wire
`endif

// ==== test/tb_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_decode;
        import decode_pkg::*;

        localparam int DIRECTED_WORDS = 62;
        localparam int RANDOM_CYCLES  = 300;
        localparam int STIM_CYCLES    = 5 + 1 + DIRECTED_WORDS + RANDOM_CYCLES + 12;

        logic   clk;
        logic   rst;
        logic   inst_valid;
        inst_t  inst;
        logic   ctrl_valid;
        ctrl_t  ctrl;
        ctrl_t  expected_q[$];
        ctrl_t  expected;
        int     value_errors;
        int     protocol_errors;
        integer seed;
        logic [31:0] r;
        inst_t  word;
        int     drain;

        funct_t r_functs [29] = '{FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU,
                FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLL, FN_SLLV, FN_SRL, FN_SRLV, FN_SRA,
                FN_SRAV, FN_MULT, FN_MULTU, FN_DIV, FN_DIVU, FN_MFHI, FN_MFLO, FN_MTHI,
                FN_MTLO, FN_BREAK, FN_SYSCALL, FN_JR, FN_JALR, 6'b001010}; // Last is MOVZ
        opcode_t i_ops [24] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                OP_XORI, OP_LUI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
                OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J, OP_JAL,
                6'b100010, 6'b011100}; // LWL and SPECIAL2 (CLZ)
        reg_addr_t regimm_rts [5] = '{RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL, 5'b00010};

        decode_top i_dut (
                .clk        (clk),
                .rst        (rst),
                .inst_valid (inst_valid),
                .inst       (inst),
                .ctrl_valid (ctrl_valid),
                .ctrl       (ctrl)
        );

        always #10 clk = ~clk;

        task automatic send_word(input inst_t w, input logic v);
                @(posedge clk);
                inst_valid <= v;
                inst       <= w;
                if (v)
                        expected_q.push_back(decode_ref(w));
        endtask

        task automatic check_field(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
                if (got !== want) begin
                        value_errors++;
                        $display("CHECK FAILED at %0t: %s is %0h, expected %0h",
                                 $time, name, got, want);
                end
        endtask

        task automatic check_ctrl(input ctrl_t want, input ctrl_t got);
                check_field("alu_op", 32'(got.alu_op), 32'(want.alu_op));
                check_field("alu_src", 32'(got.alu_src), 32'(want.alu_src));
                check_field("imm_ext", 32'(got.imm_ext), 32'(want.imm_ext));
                check_field("mem_type", 32'(got.mem_type), 32'(want.mem_type));
                check_field("mem_size", 32'(got.mem_size), 32'(want.mem_size));
                check_field("wb_dest", 32'(got.wb_dest), 32'(want.wb_dest));
                check_field("wb_en", 32'(got.wb_en), 32'(want.wb_en));
                check_field("load_ext", 32'(got.load_ext), 32'(want.load_ext));
                check_field("priv_inst", 32'(got.priv_inst), 32'(want.priv_inst));
                check_field("undefined_inst", 32'(got.undefined_inst),
                            32'(want.undefined_inst));
        endtask

        always @(posedge clk) begin
                if (!rst && ctrl_valid) begin
                        if (expected_q.size() == 0) begin
                                protocol_errors++;
                                $display("ctrl_valid went high at %0t with no word outstanding",
                                         $time);
                        end else begin
                                expected = expected_q.pop_front();
                                check_ctrl(expected, ctrl);
                        end
                end
        end

        initial begin
                #((STIM_CYCLES + 50) * 20);
                $display("Watchdog expired: the run did not finish in time");
                $display("Simulation failed");
                $finish;
        end

        initial begin
                seed            = 32'h9701ad14;
                value_errors    = 0;
                protocol_errors = 0;
                clk             = 1'b0;
                rst             = 1'b1;
                inst_valid      = 1'b0;
                inst            = '0;
                repeat (5) @(posedge clk);
                rst <= 1'b0;
                @(posedge clk);
                if (ctrl_valid !== 1'b0) begin
                        protocol_errors++;
                        $display("ctrl_valid was not low right after reset");
                end
                foreach (r_functs[i]) begin
                        r = $random(seed);
                        send_word({OP_SPECIAL, r[25:6], r_functs[i]}, 1'b1);
                end
                foreach (i_ops[i]) begin
                        r = $random(seed);
                        send_word({i_ops[i], r[25:0]}, 1'b1);
                end
                foreach (regimm_rts[i]) begin
                        r = $random(seed);
                        send_word({OP_REGIMM, r[25:21], regimm_rts[i], r[15:0]}, 1'b1);
                end
                r = $random(seed);
                send_word(ERET_WORD, 1'b1);
                send_word({OP_COP0, COP0_MF, r[20:0]}, 1'b1);
                send_word({OP_COP0, COP0_MT, r[20:0]}, 1'b1);
                send_word(32'h4200_0002, 1'b1); // TLBWI
                repeat (RANDOM_CYCLES) begin
                        r = $random(seed);
                        word = $random(seed);
                        if (r[2])
                                word[31:26] = OP_SPECIAL; // Bias toward R-format
                        send_word(word, r[0] | r[1]);
                end
                send_word('0, 1'b0);
                drain = 0;
                while (expected_q.size() != 0 && drain < 8) begin
                        @(posedge clk);
                        drain++;
                end
                repeat (3) @(posedge clk);
                if (expected_q.size() != 0) begin
                        protocol_errors++;
                        $display("%0d expected bundles never came out", expected_q.size());
                end
                $display("Value errors: %0d, protocol errors: %0d", value_errors,
                         protocol_errors);
                if (value_errors == 0 && protocol_errors == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        end

`include "decode_ref.svh"

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+test
src/decode_pkg.sv
src/branch_classify.sv
src/ctrl_table.sv
src/decode_top.sv
test/decode_assertions.sv
test/tb_decode.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_decode \
        -Mdir obj_dir -o sim_decode

status=0
./obj_dir/sim_decode > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation failed" sim.log; then
        echo "Run failed, see sim.log"
        exit 1
fi
echo "Run finished without failures"
